// ==== source/mboxPkg.sv ====
// Memory-box shared types, memory and requester bus structs, NXM limits
package mboxPkg;

  typedef logic [35:0] mboxWord;
  typedef logic [21:0] mboxAddr;

  // Word as stored, with odd parity over each 18-bit half
  typedef struct packed {
    logic    parL;
    logic    parR;
    mboxWord word;
  } mboxParWord;

  typedef struct packed {
    logic    cyc;
    logic    stb;
    logic    we;
    mboxAddr adr;
    mboxWord dat;
  } wbReq;

  typedef struct packed {
    logic    ack;
    logic    err;
    mboxWord dat;
  } wbRsp;

  typedef struct packed {
    logic       cyc;
    logic       stb;
    logic       we;
    mboxAddr    adr;
    mboxParWord dat;
  } memReq;

  typedef struct packed {
    logic       ack;
    mboxParWord dat;
  } memRsp;

  typedef enum logic {srcEbox, srcChan} reqSrc;

  typedef enum logic [1:0] {errNone, errNxm, errPar} errKind;

  typedef struct packed {
    errKind  kind;
    reqSrc   src;
    logic    write;
    mboxAddr addr;
  } errRecord;

  typedef enum logic [1:0] {diagStatus, diagEraAddr, diagEraInfo, diagNxmCount} diagSel;

  // Strobe wait before a reference is called nonexistent memory
  localparam int unsigned nxmLimit = 32;
  localparam int unsigned nxmCountW = 6;

endpackage

// ==== source/coreRequestArb.sv ====
// Core request arbiter, picks channel over ebox and holds core busy for the cycle
module coreRequestArb import mboxPkg::*; (
  input  logic  clk,
  input  logic  arstN,
  input  wbReq  ebox,
  input  wbReq  chan,
  input  logic  cycleDone,
  output wbReq  grantReq,
  output reqSrc grantSrc,
  output logic  coreBusy,
  output logic  chanBusy
);

  logic eboxPending;
  logic chanPending;
  logic take;

  assign eboxPending = ebox.cyc & ebox.stb;
  assign chanPending = chan.cyc & chan.stb;

  // A new request is only looked at while the core is idle
  assign take = ~coreBusy & (eboxPending | chanPending);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      coreBusy <= 1'b0;
    end else if (take) begin
      coreBusy <= 1'b1;
    end else if (cycleDone) begin
      coreBusy <= 1'b0;
    end
  end

  // Channel core busy, set only for a channel reference
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      chanBusy <= 1'b0;
    end else if (take) begin
      chanBusy <= chanPending;
    end else if (cycleDone) begin
      chanBusy <= 1'b0;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      grantSrc <= srcEbox;
    end else if (take) begin
      if (chanPending) begin
        grantSrc <= srcChan;
      end else begin
        grantSrc <= srcEbox;
      end
    end
  end

  // Request is frozen here so the requester side may change after ack
  always_ff @(posedge clk) begin
    if (take) begin
      if (chanPending) begin
        grantReq <= chan;
      end else begin
        grantReq <= ebox;
      end
    end
  end

endmodule

// ==== source/memCycleCtl.sv ====
// Memory cycle control, drives the storage bus with parity and returns responses
module memCycleCtl import mboxPkg::*; (
  input  logic           clk,
  input  logic           arstN,
  input  wbReq           grantReq,
  input  reqSrc          grantSrc,
  input  logic           coreBusy,
  input  mboxPkg::memRsp memRsp,
  input  logic           nxmHit,
  output memReq          memBus,
  output wbRsp           eboxRsp,
  output wbRsp           chanRsp,
  output logic           strobeWait,
  output logic           cycleDone,
  output logic           errEvent,
  output errRecord       errInfo
);

  logic memActive;
  logic memAck;
  logic parOkL;
  logic parOkR;
  logic parFail;
  wbRsp rsp;

  // Memory start, one clock after the grant is registered
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      memActive <= 1'b0;
    end else if (cycleDone) begin
      memActive <= 1'b0;
    end else if (coreBusy && !memActive) begin
      memActive <= 1'b1;
    end
  end

  // NXM abort takes cyc and stb down in the timeout cycle
  assign memBus.cyc = memActive & ~nxmHit;
  assign memBus.stb = memActive & ~nxmHit;
  assign memBus.we = grantReq.we;
  assign memBus.adr = grantReq.adr;
  assign memBus.dat.parL = ~^grantReq.dat[35:18];
  assign memBus.dat.parR = ~^grantReq.dat[17:0];
  assign memBus.dat.word = grantReq.dat;

  assign strobeWait = memActive;
  assign memAck = memActive & memRsp.ack & ~nxmHit;
  assign cycleDone = memActive & (memRsp.ack | nxmHit);

  // Each half with its parity bit must hold an odd number of ones
  assign parOkL = ^{memRsp.dat.parL, memRsp.dat.word[35:18]};
  assign parOkR = ^{memRsp.dat.parR, memRsp.dat.word[17:0]};
  assign parFail = memAck & ~grantReq.we & ~(parOkL & parOkR);

  always_comb begin
    rsp.ack = memAck;
    rsp.err = nxmHit;
    rsp.dat = nxmHit ? '0 : memRsp.dat.word;
  end

  // Only the granted requester sees ack or err
  assign eboxRsp = (grantSrc == srcEbox) ? rsp : '0;
  assign chanRsp = (grantSrc == srcChan) ? rsp : '0;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      errEvent <= 1'b0;
    end else begin
      errEvent <= parFail | nxmHit;
    end
  end

  always_ff @(posedge clk) begin
    if (parFail || nxmHit) begin
      errInfo.kind <= nxmHit ? errNxm : errPar;
      errInfo.src <= grantSrc;
      errInfo.write <= grantReq.we;
      errInfo.addr <= grantReq.adr;
    end
  end

endmodule

// ==== source/nxmTimer.sv ====
// Nonexistent-memory timer, counts strobe wait cycles and flags the timeout
module nxmTimer import mboxPkg::*; (
  input  logic                 clk,
  input  logic                 arstN,
  input  logic                 strobeWait,
  output logic                 nxmHit,
  output logic [nxmCountW-1:0] nxmCount
);

  logic atLimit;

  assign atLimit = (nxmCount == nxmCountW'(nxmLimit));

  // Count holds at the limit until the strobe goes away
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      nxmCount <= '0;
    end else if (!strobeWait) begin
      nxmCount <= '0;
    end else if (!atLimit) begin
      nxmCount <= nxmCount + 1'b1;
    end
  end

  // Count starts at zero on the first strobe cycle, so this lands nxmLimit cycles in
  assign nxmHit = strobeWait & atLimit;

endmodule

// ==== source/errorAddrReg.sv ====
// Error flags and error address register, frozen at the first error until cleared
module errorAddrReg import mboxPkg::*; (
  input  logic     clk,
  input  logic     arstN,
  input  logic     errEvent,
  input  errRecord errInfo,
  input  logic     errClr,
  output logic     nxmErr,
  output logic     parErr,
  output logic     eraHeld,
  output errRecord era
);

  logic nxmEvent;
  logic parEvent;

  assign nxmEvent = errEvent & (errInfo.kind == errNxm);
  assign parEvent = errEvent & (errInfo.kind == errPar);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      nxmErr <= 1'b0;
      parErr <= 1'b0;
    end else if (errClr) begin
      nxmErr <= 1'b0;
      parErr <= 1'b0;
    end else begin
      if (nxmEvent) begin
        nxmErr <= 1'b1;
      end
      if (parEvent) begin
        parErr <= 1'b1;
      end
    end
  end

  // Later errors only raise flags while the record is held
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      eraHeld <= 1'b0;
      era <= '0;
    end else if (errClr) begin
      eraHeld <= 1'b0;
      era <= '0;
    end else if (errEvent && !eraHeld) begin
      eraHeld <= 1'b1;
      era <= errInfo;
    end
  end

endmodule

// ==== source/diagStatusRead.sv ====
// Diagnostic read mux for status, error record and NXM timer
module diagStatusRead import mboxPkg::*; (
  input  logic                 diagRd,
  input  diagSel               sel,
  input  logic                 coreBusy,
  input  logic                 chanBusy,
  input  logic                 nxmErr,
  input  logic                 parErr,
  input  logic                 eraHeld,
  input  errRecord             era,
  input  logic [nxmCountW-1:0] nxmCount,
  output mboxWord              diagData
);

  mboxWord selWord;

  always_comb begin
    case (sel)
      // coreBusy in bit 4 down to eraHeld in bit 0
      diagStatus:   selWord = {31'b0, coreBusy, chanBusy, nxmErr, parErr, eraHeld};
      diagEraAddr:  selWord = 36'(era.addr);
      diagEraInfo:  selWord = 36'({era.kind, era.src, era.write});
      diagNxmCount: selWord = 36'(nxmCount);
      default:      selWord = '0;
    endcase
  end

  assign diagData = diagRd ? selWord : '0;

endmodule

// ==== source/mboxCtl.sv ====
// Memory-box control top, two requester ports onto one storage bus with diagnostics
module mboxCtl import mboxPkg::*; (
  input  logic           clk,
  input  logic           arstN,
  input  wbReq           ebox,
  input  wbReq           chan,
  input  mboxPkg::memRsp memRsp,
  input  logic           diagRd,
  input  diagSel         diagSelect,
  input  logic           errClr,
  output wbRsp           eboxRsp,
  output wbRsp           chanRsp,
  output memReq          memBus,
  output mboxWord        diagData
);

  wbReq                 grantReq;
  reqSrc                grantSrc;
  logic                 coreBusy;
  logic                 chanBusy;
  logic                 cycleDone;
  logic                 strobeWait;
  logic                 nxmHit;
  logic [nxmCountW-1:0] nxmCount;
  logic                 errEvent;
  errRecord             errInfo;
  logic                 nxmErr;
  logic                 parErr;
  logic                 eraHeld;
  errRecord             era;

  coreRequestArb arb (
    .clk      (clk),
    .arstN    (arstN),
    .ebox     (ebox),
    .chan     (chan),
    .cycleDone(cycleDone),
    .grantReq (grantReq),
    .grantSrc (grantSrc),
    .coreBusy (coreBusy),
    .chanBusy (chanBusy)
  );

  memCycleCtl memCyc (
    .clk       (clk),
    .arstN     (arstN),
    .grantReq  (grantReq),
    .grantSrc  (grantSrc),
    .coreBusy  (coreBusy),
    .memRsp    (memRsp),
    .nxmHit    (nxmHit),
    .memBus    (memBus),
    .eboxRsp   (eboxRsp),
    .chanRsp   (chanRsp),
    .strobeWait(strobeWait),
    .cycleDone (cycleDone),
    .errEvent  (errEvent),
    .errInfo   (errInfo)
  );

  nxmTimer nxm (
    .clk       (clk),
    .arstN     (arstN),
    .strobeWait(strobeWait),
    .nxmHit    (nxmHit),
    .nxmCount  (nxmCount)
  );

  errorAddrReg eraReg (
    .clk     (clk),
    .arstN   (arstN),
    .errEvent(errEvent),
    .errInfo (errInfo),
    .errClr  (errClr),
    .nxmErr  (nxmErr),
    .parErr  (parErr),
    .eraHeld (eraHeld),
    .era     (era)
  );

  diagStatusRead diag (
    .diagRd  (diagRd),
    .sel     (diagSelect),
    .coreBusy(coreBusy),
    .chanBusy(chanBusy),
    .nxmErr  (nxmErr),
    .parErr  (parErr),
    .eraHeld (eraHeld),
    .era     (era),
    .nxmCount(nxmCount),
    .diagData(diagData)
  );

endmodule

// ==== dv/mboxMemModel.sv ====
// Storage slave for the testbench, populated words ack and anything above never answers
module mboxMemModel import mboxPkg::*; #(
  parameter int memWords = 4096
) (
  input  logic           clk,
  input  logic           arstN,
  input  memReq          memBus,
  input  logic           bdWe,
  input  mboxAddr        bdAdr,
  input  mboxParWord     bdDat,
  output mboxPkg::memRsp memRsp
);

  localparam int addrBits = $clog2(memWords);

  mboxParWord store [memWords];
  logic hit;

  assign hit = memBus.cyc & memBus.stb & ~memRsp.ack & (32'(memBus.adr) < memWords);

  // Fill pattern built from every address bit, with good parity
  initial begin
    mboxWord w;
    for (int i = 0; i < memWords; i++) begin
      w = {12'(i), ~12'(i), 12'(i)};
      store[addrBits'(i)] = '{parL: ~^w[35:18], parR: ~^w[17:0], word: w};
    end
  end

  // One wait state, ack is a single-cycle pulse
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      memRsp <= '0;
    end else begin
      memRsp.ack <= hit;
      if (hit) begin
        // A write echoes its word back on the data lines
        memRsp.dat <= memBus.we ? memBus.dat : store[memBus.adr[addrBits-1:0]];
      end
    end
  end

  always @(posedge clk) begin
    if (hit && memBus.we) begin
      store[memBus.adr[addrBits-1:0]] <= memBus.dat;
    end
    if (bdWe) begin
      store[bdAdr[addrBits-1:0]] <= bdDat;
    end
  end

endmodule

// ==== dv/mboxCtlTb.sv ====
// Memory-box control testbench, random and directed accesses with diagnostic checks
module mboxCtlTb import mboxPkg::*; ();

  localparam int memWords = 4096;
  localparam int addrBits = 12;
  localparam int timeoutCycles = 40 * (nxmLimit + 8);

  logic           clk = 1'b0;
  logic           arstN;
  wbReq           ebox;
  wbReq           chan;
  mboxPkg::memRsp memRsp;
  logic           diagRd;
  diagSel         diagSelect;
  logic           errClr;
  wbRsp           eboxRsp;
  wbRsp           chanRsp;
  memReq          memBus;
  mboxWord        diagData;
  logic           bdWe;
  mboxAddr        bdAdr;
  mboxParWord     bdDat;

  // Shadow of storage and the error state the DUT should show
  mboxWord     shadow [memWords];
  logic        badPar [memWords];
  logic        expNxm;
  logic        expPar;
  logic        expHeld;
  errRecord    expEra;
  int unsigned cycles = 0;

  always #50 clk = ~clk;

  mboxCtl uut (
    .clk       (clk),
    .arstN     (arstN),
    .ebox      (ebox),
    .chan      (chan),
    .memRsp    (memRsp),
    .diagRd    (diagRd),
    .diagSelect(diagSelect),
    .errClr    (errClr),
    .eboxRsp   (eboxRsp),
    .chanRsp   (chanRsp),
    .memBus    (memBus),
    .diagData  (diagData)
  );

  mboxMemModel #(.memWords(memWords)) memModel (
    .clk   (clk),
    .arstN (arstN),
    .memBus(memBus),
    .bdWe  (bdWe),
    .bdAdr (bdAdr),
    .bdDat (bdDat),
    .memRsp(memRsp)
  );

  task automatic failRun(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "run stopped at the first error");
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == timeoutCycles) begin
      failRun($sformatf("Timeout after %0d cycles, the DUT stopped answering", cycles));
    end
  end

  task automatic checkWord(input string name, input mboxWord exp, input mboxWord act);
    if (exp !== act) begin
      failRun($sformatf("FAIL %s: expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic checkRsp(input string name, input wbRsp exp, input wbRsp act);
    if (exp !== act) begin
      failRun($sformatf("FAIL %s: expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic checkRecord(input string name, input errRecord exp, input errRecord act);
    if (exp !== act) begin
      failRun($sformatf("FAIL %s: expected %h actual %h", name, exp, act));
    end
  endtask

  function automatic mboxWord fillWord(input int i);
    return {12'(i), ~12'(i), 12'(i)};
  endfunction

  // Expected response and error record; writes update the shadow
  function automatic void refAccess(input reqSrc src, input logic we, input mboxAddr adr,
                                    input mboxWord wdat, output wbRsp rsp,
                                    output errRecord rec, output logic isErr);
    rsp = '0;
    rec = '{kind: errNone, src: src, write: we, addr: adr};
    isErr = 1'b0;
    if (32'(adr) >= memWords) begin
      rsp.err = 1'b1;
      rec.kind = errNxm;
      isErr = 1'b1;
    end else if (we) begin
      rsp.ack = 1'b1;
      rsp.dat = wdat;
      shadow[adr[addrBits-1:0]] = wdat;
      badPar[adr[addrBits-1:0]] = 1'b0;
    end else begin
      rsp.ack = 1'b1;
      rsp.dat = shadow[adr[addrBits-1:0]];
      if (badPar[adr[addrBits-1:0]]) begin
        rec.kind = errPar;
        isErr = 1'b1;
      end
    end
  endfunction

  // Holds the request until ack or err and counts memory strobe cycles meanwhile
  task automatic access(input reqSrc src, input logic we, input mboxAddr adr,
                        input mboxWord wdat, output wbRsp got, output int stbCycles);
    wbReq req;
    wbRsp rsp;
    logic done;
    req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
    stbCycles = 0;
    done = 1'b0;
    @(posedge clk);
    if (src == srcChan) begin
      chan <= req;
    end else begin
      ebox <= req;
    end
    while (!done) begin
      @(negedge clk);
      rsp = (src == srcChan) ? chanRsp : eboxRsp;
      if (rsp.ack || rsp.err) begin
        got = rsp;
        done = 1'b1;
      end else if (memBus.stb) begin
        stbCycles++;
      end
    end
    @(posedge clk);
    if (src == srcChan) begin
      chan <= '0;
    end else begin
      ebox <= '0;
    end
  endtask

  task automatic runAccess(input string name, input reqSrc src, input logic we,
                           input mboxAddr adr, input mboxWord wdat);
    wbRsp     expRsp;
    wbRsp     got;
    errRecord rec;
    logic     isErr;
    int       stbCycles;
    refAccess(src, we, adr, wdat, expRsp, rec, isErr);
    access(src, we, adr, wdat, got, stbCycles);
    checkRsp(name, expRsp, got);
    if (expRsp.err) begin
      checkWord({name, " strobe cycles"}, 36'(nxmLimit), 36'(stbCycles));
    end
    if (isErr) begin
      expNxm = expNxm | (rec.kind == errNxm);
      expPar = expPar | (rec.kind == errPar);
      if (!expHeld) begin
        expHeld = 1'b1;
        expEra = rec;
      end
    end
  endtask

  task automatic readDiag(input diagSel sel, output mboxWord word);
    @(posedge clk);
    diagRd <= 1'b1;
    diagSelect <= sel;
    @(negedge clk);
    word = diagData;
  endtask

  task automatic checkDiag(input string name);
    mboxWord  status;
    mboxWord  addrWord;
    mboxWord  info;
    errRecord got;
    readDiag(diagStatus, status);
    readDiag(diagEraAddr, addrWord);
    readDiag(diagEraInfo, info);
    @(posedge clk);
    diagRd <= 1'b0;
    got.kind = errKind'(info[3:2]);
    got.src = reqSrc'(info[1]);
    got.write = info[0];
    got.addr = addrWord[21:0];
    checkWord({name, " status"}, {31'b0, 2'b00, expNxm, expPar, expHeld}, status);
    checkRecord({name, " record"}, expEra, got);
  endtask

  // Timer count and busy bits read partway through a memory cycle that never acks
  task automatic watchStall(input string name, input reqSrc src);
    mboxWord count;
    mboxWord status;
    do begin
      @(negedge clk);
    end while (!memBus.stb);
    repeat (nxmLimit / 2) @(posedge clk);
    readDiag(diagNxmCount, count);
    readDiag(diagStatus, status);
    @(posedge clk);
    diagRd <= 1'b0;
    checkWord({name, " nxm count"}, 36'(nxmLimit / 2 + 1), count);
    checkWord({name, " busy status"},
              {31'b0, 1'b1, src == srcChan, expNxm, expPar, expHeld}, status);
  endtask

  task automatic pulseClear();
    @(posedge clk);
    errClr <= 1'b1;
    @(posedge clk);
    errClr <= 1'b0;
    expNxm = 1'b0;
    expPar = 1'b0;
    expHeld = 1'b0;
    expEra = '0;
  endtask

  // Left parity bit is flipped so the left half reads back even
  task automatic corrupt(input mboxAddr adr, input mboxWord word);
    @(posedge clk);
    bdWe <= 1'b1;
    bdAdr <= adr;
    bdDat <= '{parL: ^word[35:18], parR: ~^word[17:0], word: word};
    @(posedge clk);
    bdWe <= 1'b0;
    shadow[adr[addrBits-1:0]] = word;
    badPar[adr[addrBits-1:0]] = 1'b1;
  endtask

  task automatic watchFirstAdr(output mboxAddr adr);
    @(posedge clk);
    do begin
      @(negedge clk);
    end while (!memBus.stb);
    adr = memBus.adr;
  endtask

  initial begin
    reqSrc   src;
    logic    we;
    mboxAddr a;
    mboxWord w;
    mboxAddr chanAdr;
    mboxAddr eboxAdr;
    mboxAddr firstAdr;
    void'($urandom(32'h3ee5_43d3));
    arstN = 1'b0;
    ebox = '0;
    chan = '0;
    diagRd = 1'b0;
    diagSelect = diagStatus;
    errClr = 1'b0;
    bdWe = 1'b0;
    bdAdr = '0;
    bdDat = '0;
    for (int i = 0; i < memWords; i++) begin
      shadow[i] = fillWord(i);
      badPar[i] = 1'b0;
    end
    expNxm = 1'b0;
    expPar = 1'b0;
    expHeld = 1'b0;
    expEra = '0;
    repeat (10) @(posedge clk);
    arstN <= 1'b1;
    @(negedge clk);
    checkWord("reset idle diagData", '0, diagData);
    checkDiag("reset");

    for (int i = 0; i < 24; i++) begin
      src = reqSrc'($urandom_range(0, 1));
      we = 1'($urandom_range(0, 1));
      if ($urandom_range(0, 1) == 1) begin
        a = 22'($urandom_range(0, 7));
      end else begin
        a = 22'($urandom_range(0, memWords - 1));
      end
      w = mboxWord'({$urandom, $urandom});
      runAccess($sformatf("random access %0d", i), src, we, a, w);
    end
    checkDiag("random access");

    // Both ports at once so the channel must go first
    chanAdr = 22'($urandom_range(0, memWords / 2 - 1));
    eboxAdr = 22'($urandom_range(memWords / 2, memWords - 1));
    w = mboxWord'({$urandom, $urandom});
    fork
      runAccess("simultaneous chan", srcChan, 1'b1, chanAdr, w);
      runAccess("simultaneous ebox", srcEbox, 1'b0, eboxAdr, '0);
      watchFirstAdr(firstAdr);
    join
    checkWord("simultaneous order", 36'(chanAdr), 36'(firstAdr));
    checkDiag("simultaneous");

    fork
      runAccess("nxm read", srcEbox, 1'b0, 22'(memWords + $urandom_range(0, 999)), '0);
      watchStall("nxm read", srcEbox);
    join
    checkDiag("nxm read");
    // Selector still points at a nonzero error info word here
    @(negedge clk);
    checkWord("nxm read idle diagData", '0, diagData);
    pulseClear();
    checkDiag("clear after nxm");

    a = 22'($urandom_range(0, memWords - 1));
    corrupt(a, mboxWord'({$urandom, $urandom}));
    runAccess("parity read", srcChan, 1'b0, a, '0);
    checkDiag("parity read");

    w = mboxWord'({$urandom, $urandom});
    runAccess("second error", srcEbox, 1'b1, 22'(memWords + $urandom_range(0, 999)), w);
    checkDiag("second error held");
    pulseClear();
    checkDiag("clear after second error");
    fork
      runAccess("error after clear", srcChan, 1'b0, 22'(memWords * 2), '0);
      watchStall("error after clear", srcChan);
    join
    checkDiag("error after clear");

    $display("*** PASSED ***");
    $finish;
  end

endmodule

// ==== mboxCtl.f ====
source/mboxPkg.sv
source/coreRequestArb.sv
source/memCycleCtl.sv
source/nxmTimer.sv
source/errorAddrReg.sv
source/diagStatusRead.sv
source/mboxCtl.sv
dv/mboxMemModel.sv
dv/mboxCtlTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS ?= --binary --timing -j 0
TOP ?= mboxCtlTb
FILELIST ?= mboxCtl.f
OBJDIR ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
